// ==== hw/glitc_defines.svh ====
/*
 * Build constants for the trigger slice: version word fields,
 * APB register byte offsets, power FIFO depth and window length.
 */
`ifndef GLITC_DEFINES_SVH
`define GLITC_DEFINES_SVH

////////////////////////////////////////////////////////////
// Version word fields, packed MSB first in this order.
////////////////////////////////////////////////////////////
`define GLITC_VER_BOARDREV 4'd0
`define GLITC_VER_MONTH    4'd3
`define GLITC_VER_DAY      8'd14
`define GLITC_VER_MAJOR    4'd1
`define GLITC_VER_MINOR    4'd2
`define GLITC_VER_REV      8'd7

////////////////////////////////////////////////////////////
// Register byte offsets, sized to the APB address.
////////////////////////////////////////////////////////////
`define GLITC_REG_VERSION  12'h000
`define GLITC_REG_CTRL     12'h004
`define GLITC_REG_PEAK     12'h008
`define GLITC_REG_STATUS   12'h00C

// Power FIFO entries, must be a power of two.
`define GLITC_FIFO_DEPTH   16

// Beats per trigger window.
`define GLITC_WINDOW_BEATS 64

`endif

// ==== hw/glitc_pkg.sv ====
/*
 * Shared types for the trigger slice: sample beat, power and peak
 * records, control word, version word and APB request/response.
 */
package glitc_pkg;

	// One deserialized beat of four signed samples.
	typedef struct packed {
		logic              valid;
		logic signed [11:0] s3;
		logic signed [11:0] s2;
		logic signed [11:0] s1;
		logic signed [11:0] s0;
	} sample_beat_t;

	// Power of one beat and its position in the window.
	typedef struct packed {
		logic [5:0]  idx;
		logic [15:0] power;
	} power_rec_t;

	// Window maximum, same layout as the PEAK register.
	typedef struct packed {
		logic [5:0]  idx;
		logic [15:0] power;
	} peak_rec_t;

	// Control word, enable in bit 0.
	typedef struct packed {
		logic [3:0] shift;
		logic       enable;
	} glitc_ctrl_t;

	typedef struct packed {
		logic [3:0] boardrev;
		logic [3:0] month;
		logic [7:0] day;
		logic [3:0] major;
		logic [3:0] minor;
		logic [7:0] rev;
	} version_t;

	// APB master to slave.
	typedef struct packed {
		logic [11:0] paddr;
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	// APB slave to master.
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

// ==== hw/power_estimator.sv ====
/*
 * Power estimator: squares and sums the four samples of each beat,
 * shifts and saturates the sum, and tags it with its window index.
 */
`timescale 1ns/1ps
`include "glitc_defines.svh"

module power_estimator (
	input  logic                   sysclk_i,
	input  logic                   rst_n_i,
	input  glitc_pkg::sample_beat_t beat_i,
	input  logic                   sync_i,
	input  glitc_pkg::glitc_ctrl_t  ctrl_i,
	output glitc_pkg::power_rec_t   rec_o,
	output logic                   push_o
);
	import glitc_pkg::*;

	localparam int SQ_W  = 23;
	localparam int SUM_W = SQ_W + 2;
	localparam int IDX_W = $clog2(`GLITC_WINDOW_BEATS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`GLITC_WINDOW_BEATS - 1);

	logic [IDX_W-1:0] idx_q;
	logic [IDX_W-1:0] beat_idx;
	logic             s1_valid_q;
	logic [IDX_W-1:0] s1_idx_q;
	logic [SQ_W-1:0]  s1_sq_q [4];
	logic [SUM_W-1:0] s2_sum;
	logic [SUM_W-1:0] s2_shifted;
	power_rec_t       s2_rec;

	// Square of a 12-bit sample, at most 2^22 so 23 bits hold it.
	function automatic logic [SQ_W-1:0] square(input logic signed [11:0] x);
		logic signed [23:0] p;
		p = x * x;
		return p[SQ_W-1:0];
	endfunction

	// Sync forces index 0 on its own beat.
	assign beat_idx = sync_i ? '0 : idx_q;

	////////////////////////////////////////////////////////////
	// Stage one: squares and index.
	////////////////////////////////////////////////////////////
	always_ff @(posedge sysclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			idx_q      <= '0;
			s1_valid_q <= 1'b0;
		end else begin
			s1_valid_q <= beat_i.valid;
			if (beat_i.valid) begin
				idx_q <= (beat_idx == LAST_IDX) ? '0 : beat_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge sysclk_i) begin
		if (beat_i.valid) begin
			s1_sq_q[0] <= square(beat_i.s0);
			s1_sq_q[1] <= square(beat_i.s1);
			s1_sq_q[2] <= square(beat_i.s2);
			s1_sq_q[3] <= square(beat_i.s3);
			s1_idx_q   <= beat_idx;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage two: sum, shift, saturate.
	////////////////////////////////////////////////////////////
	always_comb begin
		s2_sum = SUM_W'(s1_sq_q[0]) + SUM_W'(s1_sq_q[1]) +
		         SUM_W'(s1_sq_q[2]) + SUM_W'(s1_sq_q[3]);
		s2_shifted   = s2_sum >> ctrl_i.shift;
		s2_rec.idx   = s1_idx_q;
		s2_rec.power = (|s2_shifted[SUM_W-1:16]) ? 16'hFFFF : s2_shifted[15:0];
	end

	always_ff @(posedge sysclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			push_o <= 1'b0;
		end else begin
			push_o <= s1_valid_q;
		end
	end

	always_ff @(posedge sysclk_i) begin
		if (s1_valid_q) begin
			rec_o <= s2_rec;
		end
	end

endmodule

// ==== hw/power_fifo.sv ====
/*
 * Synchronous FIFO of power records. A push into a full FIFO
 * is dropped and reported as a one-cycle overflow pulse.
 */
`timescale 1ns/1ps
`include "glitc_defines.svh"

module power_fifo (
	input  logic                 sysclk_i,
	input  logic                 rst_n_i,
	input  glitc_pkg::power_rec_t rec_i,
	input  logic                 push_i,
	input  logic                 pop_i,
	output glitc_pkg::power_rec_t rec_o,
	output logic                 empty_o,
	output logic                 overflow_o
);
	import glitc_pkg::*;

	localparam int DEPTH = `GLITC_FIFO_DEPTH;
	localparam int AW    = $clog2(DEPTH);

	power_rec_t  mem [DEPTH];
	logic [AW:0] wr_ptr_q;
	logic [AW:0] rd_ptr_q;
	logic        full;
	logic        do_push;
	logic        do_pop;

	// Pointers carry one extra wrap bit to tell full from empty.
	assign empty_o = (wr_ptr_q == rd_ptr_q);
	assign full    = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
	                 (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

	assign do_push = push_i && !full;
	assign do_pop  = pop_i && !empty_o;

	// Head of queue, valid whenever not empty.
	assign rec_o = mem[rd_ptr_q[AW-1:0]];

	always_ff @(posedge sysclk_i) begin
		if (do_push) begin
			mem[wr_ptr_q[AW-1:0]] <= rec_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers and overflow.
	////////////////////////////////////////////////////////////
	always_ff @(posedge sysclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// Full is judged before this cycle's pop.
			overflow_o <= push_i && full;
		end
	end

endmodule

// ==== hw/peak_tracker.sv ====
/*
 * Peak tracker: drains power records, keeps the running maximum
 * of each window and publishes it at the last beat of the window.
 */
`timescale 1ns/1ps
`include "glitc_defines.svh"

module peak_tracker (
	input  logic                  sysclk_i,
	input  logic                  rst_n_i,
	input  glitc_pkg::glitc_ctrl_t ctrl_i,
	input  glitc_pkg::power_rec_t  rec_i,
	input  logic                  empty_i,
	output logic                  pop_o,
	output glitc_pkg::peak_rec_t   peak_o,
	output logic                  done_o
);
	import glitc_pkg::*;

	localparam int IDX_W = $clog2(`GLITC_WINDOW_BEATS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`GLITC_WINDOW_BEATS - 1);

	power_rec_t run_q;
	power_rec_t run_d;
	logic       first_beat;
	logic       last_beat;

	// Drain whenever allowed, one record per cycle.
	assign pop_o = !empty_i && ctrl_i.enable;

	assign first_beat = (rec_i.idx == '0);
	assign last_beat  = (rec_i.idx == LAST_IDX);

	////////////////////////////////////////////////////////////
	// Running maximum.
	////////////////////////////////////////////////////////////
	always_comb begin
		run_d = run_q;
		// Strictly greater, so a tie keeps the earlier index.
		if (first_beat || (rec_i.power > run_q.power)) begin
			run_d = rec_i;
		end
	end

	always_ff @(posedge sysclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			run_q  <= '0;
			peak_o <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (pop_o) begin
				run_q <= run_d;
				if (last_beat) begin
					peak_o.power <= run_d.power;
					peak_o.idx   <= run_d.idx;
					done_o       <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== hw/glitc_control_regs.sv ====
/*
 * APB register slave: version word, control, latest peak result
 * and status with window count and sticky FIFO overflow.
 */
`timescale 1ns/1ps
`include "glitc_defines.svh"

module glitc_control_regs (
	input  logic                  sysclk_i,
	input  logic                  rst_n_i,
	input  glitc_pkg::apb_req_t    apb_req_i,
	output glitc_pkg::apb_rsp_t    apb_rsp_o,
	output glitc_pkg::glitc_ctrl_t ctrl_o,
	input  glitc_pkg::peak_rec_t   peak_i,
	input  logic                  peak_done_i,
	input  logic                  overflow_i
);
	import glitc_pkg::*;

	localparam version_t VERSION = '{
		boardrev: `GLITC_VER_BOARDREV,
		month:    `GLITC_VER_MONTH,
		day:      `GLITC_VER_DAY,
		major:    `GLITC_VER_MAJOR,
		minor:    `GLITC_VER_MINOR,
		rev:      `GLITC_VER_REV
	};

	logic        access;
	logic        wr_en;
	logic        rd_en;
	logic        wr_ctrl;
	logic        wr_status;
	logic        mapped;
	logic [31:0] rd_data;
	logic [15:0] win_count_q;
	logic        overflow_q;

	////////////////////////////////////////////////////////////
	// APB access decode.
	////////////////////////////////////////////////////////////
	// Access phase only, setup cycles are ignored.
	assign access = apb_req_i.psel && apb_req_i.penable;
	assign wr_en  = access && apb_req_i.pwrite;
	assign rd_en  = access && !apb_req_i.pwrite;

	assign wr_ctrl   = wr_en && (apb_req_i.paddr == `GLITC_REG_CTRL);
	assign wr_status = wr_en && (apb_req_i.paddr == `GLITC_REG_STATUS);

	always_comb begin
		rd_data = '0;
		mapped  = 1'b1;
		case (apb_req_i.paddr)
			`GLITC_REG_VERSION: rd_data = VERSION;
			`GLITC_REG_CTRL:    rd_data = {27'b0, ctrl_o};
			`GLITC_REG_PEAK:    rd_data = {10'b0, peak_i};
			`GLITC_REG_STATUS:  rd_data = {15'b0, overflow_q, win_count_q};
			default:            mapped  = 1'b0;
		endcase
	end

	// Zero wait states, error only on unmapped reads.
	always_comb begin
		apb_rsp_o.prdata  = rd_en ? rd_data : '0;
		apb_rsp_o.pready  = 1'b1;
		apb_rsp_o.pslverr = rd_en && !mapped;
	end

	////////////////////////////////////////////////////////////
	// Control and status registers.
	////////////////////////////////////////////////////////////
	always_ff @(posedge sysclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ctrl_o      <= '0;
			win_count_q <= '0;
			overflow_q  <= 1'b0;
		end else begin
			if (wr_ctrl) begin
				ctrl_o <= glitc_ctrl_t'(apb_req_i.pwdata[$bits(glitc_ctrl_t)-1:0]);
			end
			// A write to STATUS wins over events in the same cycle.
			if (wr_status) begin
				win_count_q <= '0;
				overflow_q  <= 1'b0;
			end else begin
				if (peak_done_i) begin
					win_count_q <= win_count_q + 16'd1;
				end
				if (overflow_i) begin
					overflow_q <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== hw/glitc_trigger_top.sv ====
/*
 * Trigger slice top: APB registers, power estimator, power FIFO
 * and peak tracker on the single system clock.
 */
`timescale 1ns/1ps

module glitc_trigger_top (
	input  logic                   sysclk_i,
	input  logic                   rst_n_i,
	input  glitc_pkg::apb_req_t     apb_req_i,
	output glitc_pkg::apb_rsp_t     apb_rsp_o,
	input  glitc_pkg::sample_beat_t beat_i,
	input  logic                   sync_i
);
	import glitc_pkg::*;

	// Control word from the register block.
	glitc_ctrl_t ctrl;
	// Estimator to FIFO.
	power_rec_t  est_rec;
	logic        est_push;
	// FIFO to tracker.
	power_rec_t  head_rec;
	logic        fifo_empty;
	logic        fifo_pop;
	logic        fifo_overflow;
	// Tracker result back to the registers.
	peak_rec_t   peak;
	logic        peak_done;

	glitc_control_regs u_regs (
		.sysclk_i   (sysclk_i),
		.rst_n_i    (rst_n_i),
		.apb_req_i  (apb_req_i),
		.apb_rsp_o  (apb_rsp_o),
		.ctrl_o     (ctrl),
		.peak_i     (peak),
		.peak_done_i(peak_done),
		.overflow_i (fifo_overflow)
	);

	power_estimator u_estimator (
		.sysclk_i(sysclk_i),
		.rst_n_i (rst_n_i),
		.beat_i  (beat_i),
		.sync_i  (sync_i),
		.ctrl_i  (ctrl),
		.rec_o   (est_rec),
		.push_o  (est_push)
	);

	power_fifo u_fifo (
		.sysclk_i  (sysclk_i),
		.rst_n_i   (rst_n_i),
		.rec_i     (est_rec),
		.push_i    (est_push),
		.pop_i     (fifo_pop),
		.rec_o     (head_rec),
		.empty_o   (fifo_empty),
		.overflow_o(fifo_overflow)
	);

	peak_tracker u_tracker (
		.sysclk_i(sysclk_i),
		.rst_n_i (rst_n_i),
		.ctrl_i  (ctrl),
		.rec_i   (head_rec),
		.empty_i (fifo_empty),
		.pop_o   (fifo_pop),
		.peak_o  (peak),
		.done_o  (peak_done)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
/*
 * Testbench clock and reset: 10 ns clock, reset low for 16 cycles.
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);
	localparam real HALF_PERIOD  = 5.0;
	localparam int  RESET_CYCLES = 16;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

// ==== dv/glitc_trigger_tb.sv ====
/*
 * Trace-driven testbench for the trigger slice: APB access task,
 * beat driver with LFSR idle gaps, window polling and value checks.
 */
`timescale 1ns/1ps
`include "glitc_defines.svh"

module glitc_trigger_tb;
	import glitc_pkg::*;

	localparam int POLL_LIMIT    = 200;
	localparam int RESET_TIMEOUT = 64;
	// Push lands two cycles after a beat and sticky overflow two cycles later.
	localparam int FLUSH_CYCLES  = 4;

	logic         clk;
	logic         rst_n;
	apb_req_t     apb_req;
	apb_rsp_t     apb_rsp;
	sample_beat_t beat;
	logic         sync;
	logic [31:0]  lfsr_q;
	int           errors;
	int           checks;
	int           tests;
	int           failed_tests;
	int           test_errors;
	string        test_name;

	tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

	glitc_trigger_top glitc_trigger_top_i (
		.sysclk_i (clk),
		.rst_n_i  (rst_n),
		.apb_req_i(apb_req),
		.apb_rsp_o(apb_rsp),
		.beat_i   (beat),
		.sync_i   (sync)
	);

	////////////////////////////////////////////////////////////
	// Helpers.
	////////////////////////////////////////////////////////////
	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	task automatic note_failure();
		errors++;
		test_errors++;
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			$display("error %s expected %h actual %h", name, exp, act);
			note_failure();
		end
	endtask

	task automatic close_test();
		if (test_name != "") begin
			tests++;
			if (test_errors != 0) begin
				failed_tests++;
			end
			$display("test %s: %s", test_name, (test_errors == 0) ? "ok" : "failed");
		end
		test_errors = 0;
	endtask

	task automatic apb_access(input logic write, input logic [11:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		apb_req <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: write, pwdata: wdata};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		// The slave has no wait states and completes in the access cycle.
		@(negedge clk);
		compare("pready", 32'd1, {31'd0, apb_rsp.pready});
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk);
		apb_req <= '0;
	endtask

	// Repeats one beat with random idle gaps and an optional sync on the first.
	task automatic drive_beats(input int count, input int sync_first,
			input logic [11:0] s0, input logic [11:0] s1,
			input logic [11:0] s2, input logic [11:0] s3);
		int gap;
		for (int n = 0; n < count; n++) begin
			@(posedge clk);
			beat <= {1'b1, s3, s2, s1, s0};
			sync <= (sync_first != 0) && (n == 0);
			gap = 0;
			for (int b = 0; b < 2; b++) begin
				gap    = (gap << 1) | lfsr_q[0];
				lfsr_q = lfsr_step(lfsr_q);
			end
			if (gap != 0) begin
				@(posedge clk);
				beat.valid <= 1'b0;
				sync       <= 1'b0;
				repeat (gap - 1) @(posedge clk);
			end
		end
		@(posedge clk);
		beat.valid <= 1'b0;
		sync       <= 1'b0;
		repeat (FLUSH_CYCLES) @(posedge clk);
	endtask

	task automatic wait_windows(input int count);
		logic [31:0] rdata;
		logic        err;
		int          polls;
		polls = 0;
		apb_access(1'b0, `GLITC_REG_STATUS, '0, rdata, err);
		while (rdata[15:0] != count[15:0] && polls < POLL_LIMIT) begin
			apb_access(1'b0, `GLITC_REG_STATUS, '0, rdata, err);
			polls++;
		end
		if (rdata[15:0] != count[15:0]) begin
			$display("timed out waiting for window count %0d", count);
			note_failure();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Trace player.
	////////////////////////////////////////////////////////////
	initial begin
		int          fd;
		int          cycles;
		int          cnt;
		int          sflag;
		string       line;
		byte         op;
		logic [11:0] addr;
		logic [31:0] data;
		logic [31:0] rdata;
		logic        err;
		logic        exp_err;
		logic [11:0] s0;
		logic [11:0] s1;
		logic [11:0] s2;
		logic [11:0] s3;

		apb_req      = '0;
		beat         = '0;
		sync         = 1'b0;
		lfsr_q       = 32'h1af4400a;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		failed_tests = 0;
		test_errors  = 0;
		test_name    = "";

		cycles = 0;
		while (!rst_n && cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!rst_n) begin
			$display("reset was never released");
			note_failure();
		end

		fd = $fopen("dv/glitc_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file");
			note_failure();
		end else begin
			while ($fgets(line, fd) != 0) begin
				op = (line.len() > 0) ? line.getc(0) : "#";
				case (op)
					"T": begin
						close_test();
						void'($sscanf(line, "T %s", test_name));
					end
					"W": begin
						void'($sscanf(line, "W %h %h", addr, data));
						apb_access(1'b1, addr, data, rdata, err);
						compare("pslverr", 32'd0, {31'd0, err});
					end
					"R": begin
						void'($sscanf(line, "R %h %h %h", addr, data, exp_err));
						apb_access(1'b0, addr, '0, rdata, err);
						compare("prdata", data, rdata);
						compare("pslverr", {31'd0, exp_err}, {31'd0, err});
					end
					"B": begin
						void'($sscanf(line, "B %d %d %h %h %h %h", cnt, sflag, s0, s1, s2, s3));
						drive_beats(cnt, sflag, s0, s1, s2, s3);
					end
					"P": begin
						void'($sscanf(line, "P %d", cnt));
						wait_windows(cnt);
					end
					"#", "\n", "\r", " ": begin
					end
					default: begin
						$display("unknown trace line: %s", line);
						note_failure();
					end
				endcase
			end
			$fclose(fd);
		end
		close_test();

		if (checks == 0) begin
			$display("no checks were run");
			errors++;
		end
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+hw
hw/glitc_pkg.sv
hw/power_estimator.sv
hw/power_fifo.sv
hw/peak_tracker.sv
hw/glitc_control_regs.sv
hw/glitc_trigger_top.sv
dv/tb_clock_gen.sv
dv/glitc_trigger_tb.sv

// ==== dv/glitc_trace.txt ====
# T name | W offset data | R offset expect pslverr | B count sync s0 s1 s2 s3 | P windows
# Offsets, data and 12-bit samples in hex; count, sync and windows in decimal.
T version
R 000 030E1207 0
R 010 00000000 1
T ctrl
W 004 00000015
R 004 00000015 0
W 004 00000001
R 004 00000001 0
T peak
B 10 1 001 001 001 001
B 1 0 010 020 003 000
B 53 0 001 001 001 001
P 1
R 008 000A0509 0
R 00C 00000001 0
T shift
W 004 00000005
B 5 1 040 000 000 000
B 59 0 000 000 000 000
P 2
R 008 00000400 0
W 004 00000001
B 20 1 000 000 000 000
B 1 0 800 800 800 800
B 43 0 000 000 000 000
P 3
R 008 0014FFFF 0
T tie
B 5 1 000 000 000 000
B 1 0 008 000 000 000
B 10 0 000 000 000 000
B 1 0 000 FF8 000 000
B 47 0 000 000 000 000
P 4
R 008 00050040 0
T overflow
W 004 00000000
B 20 1 001 001 001 001
R 00C 00010004 0
W 00C 00000000
R 00C 00000000 0
